// File: Bender.yml
package:
  name: play_chart

sources:
  - rtl/play_pkg.sv
  - rtl/tick_gen.sv
  - rtl/count_down.sv
  - rtl/note_sequencer.sv
  - rtl/score_keeper.sv
  - rtl/note_indicator.sv
  - rtl/play_chart.sv
  - target: test
    include_dirs:
      - verif
    files:
      - verif/tb_play_chart.sv

// File: play_chart.f
+incdir+verif
rtl/play_pkg.sv
rtl/tick_gen.sv
rtl/count_down.sv
rtl/note_sequencer.sv
rtl/score_keeper.sv
rtl/note_indicator.sv
rtl/play_chart.sv
verif/tb_play_chart.sv

// File: rtl/count_down.sv
`default_nettype none
`timescale 1ns/100ps

module count_down import play_pkg::*; (
    input  logic       prog_clk,
    input  logic       rst,
    output logic [1:0] cnt_dn,
    output logic       play_st
);

    cd_state_e                      state;
    logic [$clog2(COUNT_TICKS)-1:0] cycle_cnt;

    always_ff @(posedge prog_clk or posedge rst) begin
        if (rst) begin
            state     <= CD_THREE;
            cycle_cnt <= '0;
        end else if (state != CD_GO) begin
            if (cycle_cnt == COUNT_TICKS - 1) begin
                cycle_cnt <= '0;
                case (state)
                    CD_THREE: state <= CD_TWO;
                    CD_TWO:   state <= CD_ONE;
                    CD_ONE:   state <= CD_ZERO;
                    default:  state <= CD_GO;
                endcase
            end else begin
                cycle_cnt <= cycle_cnt + 1'b1;
            end
        end
    end

    // Digit shown per state, zero stays up once play starts
    always_comb begin
        case (state)
            CD_THREE: cnt_dn = 2'd3;
            CD_TWO:   cnt_dn = 2'd2;
            CD_ONE:   cnt_dn = 2'd1;
            default:  cnt_dn = 2'd0;
        endcase
    end

    assign play_st = (state == CD_GO);

    // Once play has started the digit is frozen until reset
    a_cnt_dn_frozen: assert property (
        @(posedge prog_clk) disable iff (rst)
        play_st |=> $stable(cnt_dn) && play_st
    );

endmodule

`default_nettype wire

// File: rtl/note_indicator.sv
`default_nettype none
`timescale 1ns/100ps

module note_indicator import play_pkg::*; (
    input  logic             prog_clk,
    input  logic             rst,
    input  logic             play_st,
    input  note_t            chart_note,
    output logic [LED_W-1:0] led,
    output logic [SEG_W-1:0] seg
);

    logic [6:0] key;
    logic [1:0] oct;
    logic [2:0] key_idx;
    logic       note_ok;
    logic [6:0] key_rev;
    logic [7:0] letter_ch;
    logic [7:0] oct_ch;
    logic [7:0] digit_ch;

    assign key = chart_note[6:0];
    assign oct = chart_note[8:7];

    // Key index from the one-hot key
    // A rest, several keys or both octave bits make the note invalid
    always_comb begin
        key_idx = 3'd0;
        note_ok = (oct != 2'b11);
        case (key)
            7'b0000001: key_idx = 3'd0;
            7'b0000010: key_idx = 3'd1;
            7'b0000100: key_idx = 3'd2;
            7'b0001000: key_idx = 3'd3;
            7'b0010000: key_idx = 3'd4;
            7'b0100000: key_idx = 3'd5;
            7'b1000000: key_idx = 3'd6;
            default:    note_ok = 1'b0;
        endcase
    end

    // C lands on the top LED
    always_comb begin
        for (int i = 0; i < 7; i++) begin
            key_rev[6-i] = key[i];
        end
    end

    // Letters run c..g then wrap to a, b
    assign letter_ch = (key_idx < 3'd5) ? 8'("c") + key_idx : 8'("a") + key_idx - 8'd5;
    assign digit_ch  = 8'("1") + key_idx;
    assign oct_ch    = oct[0] ? 8'("u") : (oct[1] ? 8'("d") : 8'(" "));

    always_ff @(posedge prog_clk or posedge rst) begin
        if (rst) begin
            led <= '0;
            seg <= "        ";
        end else if (play_st) begin
            led[0]   <= oct[0] | oct[1];
            led[7:1] <= note_ok ? key_rev : 7'b0;
            if (note_ok) begin
                seg <= {letter_ch, 8'(" "), oct_ch, 8'(" "), digit_ch, 24'("   ")};
            end else begin
                seg <= "        ";
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/note_sequencer.sv
`default_nettype none
`timescale 1ns/100ps

module note_sequencer import play_pkg::*; (
    input  logic             prog_clk,
    input  logic             rst,
    input  logic             note_tick,
    input  logic             play_st,
    input  logic             auto_play,
    input  logic [IDX_W:0]   chart_len,
    input  note_t            user_notes,
    input  note_t            chart_note,
    output logic [IDX_W-1:0] chart_addr,
    output logic             play_en,
    output logic [IDX_W:0]   note_count,
    output note_t            play_notes,
    output logic             rec_we,
    output logic [IDX_W-1:0] rec_addr,
    output note_t            rec_data
);

    logic song_open;

    // A zero-length chart plays forever
    assign song_open = (note_count < chart_len) || (chart_len == '0);

    // Store answers in the same cycle
    assign chart_addr = note_count[IDX_W-1:0];

    always_ff @(posedge prog_clk or posedge rst) begin
        if (rst) begin
            play_en <= 1'b0;
        end else begin
            play_en <= play_st && song_open;
        end
    end

    // Output, record and advance together on each note step
    always_ff @(posedge prog_clk or posedge rst) begin
        if (rst) begin
            note_count <= '0;
            play_notes <= '0;
            rec_we     <= 1'b0;
        end else begin
            rec_we <= 1'b0;
            if (note_tick && play_en) begin
                note_count <= note_count + 1'b1;
                play_notes <= auto_play ? chart_note : user_notes;
                rec_we     <= 1'b1;
            end
        end
    end

    // Recording payload of the current step
    always_ff @(posedge prog_clk or posedge rst) begin
        if (rst) begin
            rec_addr <= '0;
            rec_data <= '0;
        end else if (note_tick && play_en) begin
            rec_addr <= chart_addr;
            rec_data <= user_notes;
        end
    end

    // No recording outside the playing window
    a_rec_in_play: assert property (
        @(posedge prog_clk) disable iff (rst)
        rec_we |-> play_en
    );

endmodule

`default_nettype wire

// File: rtl/play_chart.sv
`default_nettype none
`timescale 1ns/100ps

module play_chart import play_pkg::*; (
    input  logic               prog_clk,
    input  logic               rst,
    input  logic [6:0]         note_keys,
    input  logic               oct_up,
    input  logic               oct_down,
    input  arrow_e             arrow,
    input  logic [7:0]         chart_id,
    input  logic               auto_play,
    input  logic               free_play,
    input  logic [IDX_W:0]     chart_len,
    input  note_t              chart_note,
    output logic [IDX_W-1:0]   chart_addr,
    output note_t              play_notes,
    output logic               rec_we,
    output logic [IDX_W-1:0]   rec_addr,
    output note_t              rec_data,
    output logic               save_valid,
    output logic [7:0]         save_chart_id,
    output logic [IDX_W:0]     save_len,
    output logic [SCORE_W-1:0] save_score,
    output logic [SCORE_W-1:0] score,
    output logic [SCORE_W-1:0] max_score,
    output logic [1:0]         cnt_dn,
    output logic               play_st,
    output logic [LED_W-1:0]   led,
    output logic [SEG_W-1:0]   seg,
    output page_e              page_state
);

    note_t          user_notes;
    logic           note_tick;
    logic           scan_tick;
    logic           play_en;
    logic [IDX_W:0] note_count;
    logic           save_req;

    assign user_notes = {oct_down, oct_up, note_keys};

    tick_gen u_tick_gen (
        .prog_clk  (prog_clk),
        .rst       (rst),
        .note_tick (note_tick),
        .scan_tick (scan_tick)
    );

    count_down u_count_down (
        .prog_clk (prog_clk),
        .rst      (rst),
        .cnt_dn   (cnt_dn),
        .play_st  (play_st)
    );

    note_sequencer u_note_sequencer (
        .prog_clk   (prog_clk),
        .rst        (rst),
        .note_tick  (note_tick),
        .play_st    (play_st),
        .auto_play  (auto_play),
        .chart_len  (chart_len),
        .user_notes (user_notes),
        .chart_note (chart_note),
        .chart_addr (chart_addr),
        .play_en    (play_en),
        .note_count (note_count),
        .play_notes (play_notes),
        .rec_we     (rec_we),
        .rec_addr   (rec_addr),
        .rec_data   (rec_data)
    );

    score_keeper u_score_keeper (
        .prog_clk   (prog_clk),
        .rst        (rst),
        .scan_tick  (scan_tick),
        .play_en    (play_en),
        .auto_play  (auto_play),
        .free_play  (free_play),
        .user_notes (user_notes),
        .chart_note (chart_note),
        .score      (score),
        .max_score  (max_score)
    );

    note_indicator u_note_indicator (
        .prog_clk   (prog_clk),
        .rst        (rst),
        .play_st    (play_st),
        .chart_note (chart_note),
        .led        (led),
        .seg        (seg)
    );

    // Arrow keys only act once play has started
    assign save_req = play_st && (arrow == ARROW_RIGHT);

    always_ff @(posedge prog_clk or posedge rst) begin
        if (rst) begin
            page_state <= PAGE_PLAY;
            save_valid <= 1'b0;
        end else begin
            save_valid <= save_req;
            // Menu is sticky until the next reset
            if (play_st && (arrow == ARROW_LEFT)) begin
                page_state <= PAGE_MENU;
            end
        end
    end

    // Save payload sampled with the request
    always_ff @(posedge prog_clk) begin
        if (save_req) begin
            save_chart_id <= chart_id;
            save_len      <= note_count;
            save_score    <= score;
        end
    end

endmodule

`default_nettype wire

// File: rtl/play_pkg.sv
`default_nettype none

package play_pkg;

    // Note encoding: [6:0] one-hot key C..B, [7] octave up, [8] octave down
    typedef logic [8:0] note_t;

    typedef enum logic [2:0] {
        ARROW_NONE,
        ARROW_UP,
        ARROW_DOWN,
        ARROW_LEFT,
        ARROW_RIGHT
    } arrow_e;

    typedef enum logic [0:0] {
        PAGE_PLAY,
        PAGE_MENU
    } page_e;

    typedef enum logic [2:0] {
        CD_THREE,
        CD_TWO,
        CD_ONE,
        CD_ZERO,
        CD_GO
    } cd_state_e;

    // Chart geometry
    localparam int CHART_LEN = 64;
    localparam int IDX_W     = 6;
    localparam int SCORE_W   = 14;

    // Tick periods in prog_clk cycles
    localparam int NOTE_TICKS  = 12;
    localparam int SCAN_TICKS  = 4;
    localparam int COUNT_TICKS = 6;

    // Points per scored scan
    localparam int PTS_MAX     = 5;
    localparam int PTS_AUTO    = 4;
    localparam int PTS_PERFECT = 5;
    localparam int PTS_GREAT   = 3;
    localparam int PTS_GOOD    = 2;

    // Display widths
    localparam int SEG_W = 64;
    localparam int LED_W = 8;

endpackage

`default_nettype wire

// File: rtl/score_keeper.sv
`default_nettype none
`timescale 1ns/100ps

module score_keeper import play_pkg::*; (
    input  logic               prog_clk,
    input  logic               rst,
    input  logic               scan_tick,
    input  logic               play_en,
    input  logic               auto_play,
    input  logic               free_play,
    input  note_t              user_notes,
    input  note_t              chart_note,
    output logic [SCORE_W-1:0] score,
    output logic [SCORE_W-1:0] max_score
);

    note_t prev_in;
    note_t prev2_in;
    logic  scored_scan;
    logic  key_down;

    // Rests and free play earn nothing
    assign scored_scan = scan_tick && play_en && !free_play && (chart_note[6:0] != '0);
    assign key_down    = (user_notes[6:0] != '0);

    always_ff @(posedge prog_clk or posedge rst) begin
        if (rst) begin
            score     <= '0;
            max_score <= '0;
            prev_in   <= '0;
            prev2_in  <= '0;
        end else if (scored_scan) begin
            max_score <= max_score + SCORE_W'(PTS_MAX);
            if (auto_play) begin
                score <= score + SCORE_W'(PTS_AUTO);
            end else if (key_down) begin
                prev_in  <= user_notes;
                prev2_in <= prev_in;
                // Older matches from late presses earn less
                if (chart_note == user_notes) begin
                    score <= score + SCORE_W'(PTS_PERFECT);
                end else if (chart_note == prev_in) begin
                    score <= score + SCORE_W'(PTS_GREAT);
                end else if (chart_note == prev2_in) begin
                    score <= score + SCORE_W'(PTS_GOOD);
                end
            end
        end
    end

    // Every scan adds at least as much to max as to score
    a_score_bounded: assert property (
        @(posedge prog_clk) disable iff (rst)
        score <= max_score
    );

endmodule

`default_nettype wire

// File: rtl/tick_gen.sv
`default_nettype none
`timescale 1ns/100ps

module tick_gen import play_pkg::*; (
    input  logic prog_clk,
    input  logic rst,
    output logic note_tick,
    output logic scan_tick
);

    logic [$clog2(NOTE_TICKS)-1:0] note_cnt;
    logic [$clog2(SCAN_TICKS)-1:0] scan_cnt;

    // Free-running dividers, both restart at reset release
    always_ff @(posedge prog_clk or posedge rst) begin
        if (rst) begin
            note_cnt <= '0;
            scan_cnt <= '0;
        end else begin
            if (note_cnt == NOTE_TICKS - 1) begin
                note_cnt <= '0;
            end else begin
                note_cnt <= note_cnt + 1'b1;
            end
            if (scan_cnt == SCAN_TICKS - 1) begin
                scan_cnt <= '0;
            end else begin
                scan_cnt <= scan_cnt + 1'b1;
            end
        end
    end

    // One-cycle enables on the last count of each period
    assign note_tick = (note_cnt == NOTE_TICKS - 1);
    assign scan_tick = (scan_cnt == SCAN_TICKS - 1);

endmodule

`default_nettype wire

// File: verif/play_chart_tests.svh
`ifndef PLAY_CHART_TESTS_SVH
`define PLAY_CHART_TESTS_SVH

// One cycle seen at the falling edge: checks, capture, then new keys
task automatic sample_cycle;
    @(negedge prog_clk);
    if (prev_play) begin
        check_equal("led", led, expected_led(prev_note));
        check_equal("seg", seg, expected_seg(prev_note));
    end
    prev_play = play_st;
    prev_note = chart_note;
    if (rec_we) begin
        check_equal("rec_addr", rec_addr, write_cnt);
        rec_mem[rec_addr] = rec_data;
        if (check_auto) begin
            check_equal("play_notes", play_notes, chart_mem[rec_addr]);
        end
        write_cnt++;
    end
    if (follow_chart) begin
        note_keys = chart_mem[chart_addr][6:0];
        oct_up = chart_mem[chart_addr][7];
        oct_down = chart_mem[chart_addr][8];
    end
endtask

task automatic run_cycles(input int n);
    repeat (n) sample_cycle();
endtask

task automatic wait_play_start;
    int guard;
    guard = 0;
    while (!play_st) begin
        sample_cycle();
        guard++;
        if (guard > 200) report_failure("play_st never rose after the countdown");
    end
endtask

task automatic run_until_writes(input int n);
    int guard;
    guard = 0;
    while (write_cnt < n) begin
        sample_cycle();
        guard++;
        if (guard > 2000) report_failure("recording writes stopped before the chart end");
    end
endtask

task automatic test_reset_values;
    apply_reset(1'b0, 1'b0, 7'd8);
    check_equal("rec_we", rec_we, 0);
    check_equal("save_valid", save_valid, 0);
    check_equal("play_st", play_st, 0);
    check_equal("led", led, 0);
    check_equal("seg", seg, "        ");
    check_equal("page_state", page_state, PAGE_PLAY);
    check_equal("cnt_dn", cnt_dn, 3);
    check_equal("score", score, 0);
    check_equal("max_score", max_score, 0);
    check_equal("play_notes", play_notes, 0);
endtask

task automatic test_countdown;
    int   expect_cnt;
    int   guard;
    logic zero_seen;
    apply_reset(1'b0, 1'b0, 7'd8);
    expect_cnt = 3;
    guard = 0;
    zero_seen = 1'b0;
    while (!play_st) begin
        sample_cycle();
        // Digit may only hold or step down by one
        if (int'(cnt_dn) != expect_cnt) begin
            check_equal("cnt_dn", cnt_dn, expect_cnt - 1);
            expect_cnt--;
        end
        if (cnt_dn == 2'd0 && !play_st) zero_seen = 1'b1;
        guard++;
        if (guard > 200) report_failure("countdown did not finish in time");
    end
    check_equal("cnt_dn at play start", zero_seen, 1);
    repeat (30) begin
        sample_cycle();
        check_equal("play_st", play_st, 1);
        check_equal("cnt_dn", cnt_dn, 0);
    end
endtask

task automatic test_auto_play;
    apply_reset(1'b1, 1'b0, 7'd20);
    wait_play_start();
    run_until_writes(20);
    run_cycles(4 * NOTE_TICKS);
    check_equal("write count", write_cnt, 20);
    check_equal("score times 5", 64'(score) * 5, 64'(max_score) * 4);
    if (max_score == '0) report_failure("max_score stayed zero in auto play");
endtask

task automatic test_manual_play;
    int i;
    apply_reset(1'b0, 1'b0, 7'd16);
    follow_chart = 1'b1;
    run_until_writes(16);
    run_cycles(2 * NOTE_TICKS);
    check_equal("score", score, max_score);
    for (i = 0; i < write_cnt; i++) begin
        check_equal("recorded note", rec_mem[i], chart_mem[i]);
    end
endtask

task automatic test_free_play_save;
    int guard;
    apply_reset(1'b0, 1'b1, 7'd8);
    run_until_writes(8);
    run_cycles(NOTE_TICKS);
    check_equal("score", score, 0);
    check_equal("max_score", max_score, 0);
    arrow = ARROW_RIGHT;
    guard = 0;
    while (!save_valid) begin
        sample_cycle();
        guard++;
        if (guard > 20) report_failure("save_valid did not rise on the right arrow");
    end
    check_equal("save_chart_id", save_chart_id, chart_id);
    check_equal("save_len", save_len, write_cnt);
    check_equal("save_score", save_score, score);
    arrow = ARROW_NONE;
endtask

task automatic test_exit;
    int guard;
    apply_reset(1'b1, 1'b0, 7'd0);
    wait_play_start();
    check_equal("page_state", page_state, PAGE_PLAY);
    arrow = ARROW_LEFT;
    guard = 0;
    while (page_state != PAGE_MENU) begin
        sample_cycle();
        guard++;
        if (guard > 20) report_failure("page did not switch to the menu on the left arrow");
    end
    arrow = ARROW_NONE;
    run_cycles(10);
    check_equal("page_state", page_state, PAGE_MENU);
endtask

`endif

// File: verif/tb_play_chart.sv
`timescale 1ns/100ps
`default_nettype none

module tb_play_chart import play_pkg::*; ();

    logic               prog_clk;
    logic               rst;
    logic [6:0]         note_keys;
    logic               oct_up, oct_down;
    arrow_e             arrow;
    logic [7:0]         chart_id;
    logic               auto_play, free_play;
    logic [IDX_W:0]     chart_len;
    note_t              chart_note;
    logic [IDX_W-1:0]   chart_addr, rec_addr;
    note_t              play_notes, rec_data;
    logic               rec_we, save_valid, play_st;
    logic [7:0]         save_chart_id;
    logic [IDX_W:0]     save_len;
    logic [SCORE_W-1:0] save_score, score, max_score;
    logic [1:0]         cnt_dn;
    logic [LED_W-1:0]   led;
    logic [SEG_W-1:0]   seg;
    page_e              page_state;

    // Chart store model and capture of recorded notes
    note_t chart_mem [CHART_LEN];
    note_t rec_mem [CHART_LEN];
    int    seed;
    int    write_cnt;
    note_t prev_note;
    logic  prev_play;
    logic  follow_chart;
    logic  check_auto;

    // Store answers combinationally, same cycle as the address
    assign chart_note = chart_mem[chart_addr];

    play_chart dut0 (.*);

    initial begin
        prog_clk = 1'b0;
        forever begin
            #5 prog_clk = ~prog_clk;
        end
    end

    task automatic check_equal(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            $display("CHECK FAILED: %s got 0x%0h expected 0x%0h", name, got, exp);
            $display("Simulation FAILED");
            $fatal(1, "Mismatch on %s", name);
        end
    endtask

    task automatic report_failure(input string what);
        $display("ERROR: %s", what);
        $display("Simulation FAILED");
        $fatal(1, "%s", what);
    endtask

    // LED pattern: bit 0 for an octave shift, C on bit 7 down to B on bit 1
    function automatic logic [LED_W-1:0] expected_led(input note_t n);
        logic [LED_W-1:0] v;
        int               k;
        v = '0;
        v[0] = n[7] | n[8];
        for (k = 0; k < 7; k++) begin
            if (n[6:0] == (7'b1 << k)) begin
                v[7-k] = 1'b1;
            end
        end
        return v;
    endfunction

    // Segment text: letter, blank, octave mark, blank, degree digit
    function automatic logic [SEG_W-1:0] expected_seg(input note_t n);
        string            letters;
        logic [SEG_W-1:0] v;
        int               k;
        letters = "cdefgab";
        v = "        ";
        for (k = 0; k < 7; k++) begin
            if (n[6:0] == (7'b1 << k)) begin
                v[63:56] = letters[k];
                v[47:40] = n[7] ? 8'("u") : (n[8] ? 8'("d") : 8'(" "));
                v[31:24] = 8'("1") + 8'(k);
            end
        end
        return v;
    endfunction

    // One-hot keys with a random octave, every fourth entry a rest
    task automatic fill_chart;
        int i;
        int k;
        int oct;
        for (i = 0; i < CHART_LEN; i++) begin
            k = $unsigned($random(seed)) % 7;
            oct = $unsigned($random(seed)) % 3;
            if (i % 4 == 3) begin
                chart_mem[i] = '0;
            end else begin
                chart_mem[i] = {(oct == 2), (oct == 1), 7'(7'b1 << k)};
            end
        end
    endtask

    task automatic apply_reset(input logic auto, input logic free, input logic [IDX_W:0] len);
        rst = 1'b1;
        note_keys = '0;
        oct_up = 1'b0;
        oct_down = 1'b0;
        arrow = ARROW_NONE;
        chart_id = 8'h5a;
        auto_play = auto;
        free_play = free;
        chart_len = len;
        write_cnt = 0;
        prev_note = '0;
        prev_play = 1'b0;
        follow_chart = 1'b0;
        check_auto = auto;
        repeat (10) @(negedge prog_clk);
        rst = 1'b0;
    endtask

    `include "play_chart_tests.svh"

    initial begin
        seed = 2323;
        rst = 1'b1;
        note_keys = '0;
        oct_up = 1'b0;
        oct_down = 1'b0;
        arrow = ARROW_NONE;
        chart_id = '0;
        auto_play = 1'b0;
        free_play = 1'b0;
        chart_len = '0;
        fill_chart();
        test_reset_values();
        test_countdown();
        test_auto_play();
        test_manual_play();
        test_free_play_save();
        test_exit();
        $display("Simulation PASSED");
        $finish;
    end

endmodule

`default_nettype wire
